// ==== include/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// instruction address width, anything from 16 to 32 bits.
`define RV_IADDR_BITS 32

// 1 honors the predicted next PC of a packet, 0 treats all as not-taken.
`define RV_BRANCH_PREDICTION 1

`endif

// ==== project.f ====
+incdir+include
src/rv_pkg.sv
src/rv_stage_buf.sv
src/rv_decode.sv
src/rv_alu2.sv
src/rv_exec_unit.sv
verification/tb_rv_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f project.f \
    --top-module tb_rv_exec_unit -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_rv_exec_unit > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== src/rv_alu2.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_alu2
(
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_flush,
    input  wire                    i_valid,
    output logic                   o_ready,
    input  wire rv_pkg::exec_req_t i_req,
    output logic                   o_valid,
    input  wire                    i_ready,
    output rv_pkg::exec_rsp_t      o_rsp
);

    localparam int   AW      = `RV_IADDR_BITS;
    localparam logic PRED_EN = (`RV_BRANCH_PREDICTION != 0);

    rv_pkg::exec_req_t req_q;
    logic              valid_q;
    logic              op_b_sel;
    logic [31:0]       op_b;
    logic [32:0]       sum;
    logic              overflow;
    logic              eq;
    logic              lts;
    logic              ltu;
    logic              cmp_result;
    logic [31:0]       bits_result;
    logic [31:0]       shl;
    logic [31:0]       shr;
    logic [31:0]       shift_result;
    logic [31:0]       alu_result;
    logic              taken;
    logic [AW-1:0]     actual_pc;
    logic [AW-1:0]     pred_pc;

    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
            valid_q <= 1'b0;
        else if (o_ready)
            valid_q <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid && o_ready)
            req_q <= i_req;
    end

    // one adder serves add, sub, compare and the memory address.
    assign op_b_sel = req_q.ctrl.arith_sub || req_q.res.cmp;
    assign op_b     = op_b_sel ? ~req_q.op2 : req_q.op2;
    assign sum      = {1'b0, req_q.op1} + {1'b0, op_b} + {32'b0, op_b_sel};
    assign overflow = (req_q.op1[31] ^ req_q.op2[31]) & (req_q.op1[31] ^ sum[31]);

    assign eq  = (req_q.op1 == req_q.op2);
    assign lts = sum[31] ^ overflow;
    assign ltu = !sum[32];                         // no carry out means a borrow.

    assign cmp_result = req_q.ctrl.cmp_inversed ^ (req_q.ctrl.cmp_lts ? lts :
                                                   req_q.ctrl.cmp_ltu ? ltu : eq);

    assign bits_result = req_q.ctrl.bits_xor ? (req_q.op1 ^ req_q.op2) :
                         req_q.ctrl.bits_or  ? (req_q.op1 | req_q.op2) :
                                               (req_q.op1 & req_q.op2);

    assign shl = req_q.op1 << req_q.op2[4:0];
    assign shr = req_q.ctrl.shift_arithmetical ? 32'($signed(req_q.op1) >>> req_q.op2[4:0])
                                               : req_q.op1 >> req_q.op2[4:0];
    assign shift_result = req_q.ctrl.arith_shr ? shr : shl;

    // the result group is one-hot, so a plain and-or mux does.
    assign alu_result = ({32{req_q.res.cmp}}   & {31'b0, cmp_result}) |
                        ({32{req_q.res.bits}}  & bits_result)         |
                        ({32{req_q.res.shift}} & shift_result)        |
                        ({32{req_q.res.arith}} & sum[31:0]);

    assign taken     = req_q.inst_jal_jalr || (req_q.inst_branch && cmp_result);
    assign actual_pc = taken ? req_q.pc_target : req_q.pc_next;
    assign pred_pc   = (PRED_EN && req_q.branch_pred.taken) ? req_q.branch_pred.target
                                                            : req_q.pc_next;

    always_comb
    begin
        o_rsp           = '0;
        o_rsp.result    = req_q.res_src.pc_next ? 32'(req_q.pc_next) :
                          req_q.csr_read        ? req_q.csr_data :
                                                  alu_result;
        o_rsp.addr      = sum[31:0];
        o_rsp.store     = req_q.store;
        o_rsp.reg_write = req_q.reg_write;
        o_rsp.rd        = req_q.rd;
        o_rsp.pc        = req_q.pc;
        o_rsp.next_pc   = actual_pc;
        o_rsp.redirect  = (actual_pc != pred_pc);
        o_rsp.res_src   = req_q.res_src;
        o_rsp.funct3    = req_q.funct3;
        o_rsp.to_trap   = req_q.to_trap;
        case (req_q.funct3[1:0])
            2'b00:   o_rsp.wdata = {4{req_q.reg_data2[7:0]}};
            2'b01:   o_rsp.wdata = {2{req_q.reg_data2[15:0]}};
            default: o_rsp.wdata = req_q.reg_data2;
        endcase
        case (req_q.funct3[1:0])
            2'b00:   o_rsp.wsel = 4'b0001 << sum[1:0];
            2'b01:   o_rsp.wsel = sum[1] ? 4'b1100 : 4'b0011;
            default: o_rsp.wsel = 4'b1111;
        endcase
    end

    assign o_valid = valid_q;

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_decode
(
    input  wire rv_pkg::fetch_pkt_t i_pkt,
    output rv_pkg::exec_req_t       o_req
);

    localparam int AW = `RV_IADDR_BITS;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt_op;
    logic [4:0]        rd;
    logic [31:0]       imm_i;
    logic [31:0]       imm_s;
    logic [31:0]       imm_b;
    logic [31:0]       imm_u;
    logic [31:0]       imm_j;
    logic [31:0]       pc_ext;
    logic [31:0]       jalr_sum;
    rv_pkg::alu_ctrl_t op_ctrl;
    rv_pkg::alu_res_t  op_res;

    assign opcode   = i_pkt.instr[6:0];
    assign funct3   = i_pkt.instr[14:12];
    assign alt_op   = i_pkt.instr[30];                // funct7 bit 5, sub and sra.
    assign rd       = i_pkt.instr[11:7];
    assign imm_i    = {{20{i_pkt.instr[31]}}, i_pkt.instr[31:20]};
    assign imm_s    = {{20{i_pkt.instr[31]}}, i_pkt.instr[31:25], i_pkt.instr[11:7]};
    assign imm_b    = {{19{i_pkt.instr[31]}}, i_pkt.instr[31], i_pkt.instr[7],
                       i_pkt.instr[30:25], i_pkt.instr[11:8], 1'b0};
    assign imm_u    = {i_pkt.instr[31:12], 12'b0};
    assign imm_j    = {{11{i_pkt.instr[31]}}, i_pkt.instr[31], i_pkt.instr[19:12],
                       i_pkt.instr[20], i_pkt.instr[30:21], 1'b0};
    assign pc_ext   = 32'(i_pkt.pc);
    assign jalr_sum = i_pkt.rs1_data + imm_i;

    // shared by OP and OP-IMM, only the register form subtracts.
    always_comb
    begin
        op_ctrl = '0;
        op_res  = '0;
        case (funct3)
            3'b000:
            begin
                op_res.arith      = 1'b1;
                op_ctrl.arith_sub = (opcode == OPC_OP) && alt_op;
            end
            3'b001: op_res.shift = 1'b1;
            3'b010:
            begin
                op_res.cmp      = 1'b1;
                op_ctrl.cmp_lts = 1'b1;
            end
            3'b011:
            begin
                op_res.cmp      = 1'b1;
                op_ctrl.cmp_ltu = 1'b1;
            end
            3'b100:
            begin
                op_res.bits      = 1'b1;
                op_ctrl.bits_xor = 1'b1;
            end
            3'b101:
            begin
                op_res.shift               = 1'b1;
                op_ctrl.arith_shr          = 1'b1;
                op_ctrl.shift_arithmetical = alt_op;
            end
            3'b110:
            begin
                op_res.bits     = 1'b1;
                op_ctrl.bits_or = 1'b1;
            end
            default: op_res.bits = 1'b1;
        endcase
    end

    always_comb
    begin
        o_req                    = '0;
        o_req.op1                = i_pkt.rs1_data;
        o_req.op2                = i_pkt.rs2_data;
        o_req.res.arith          = 1'b1;
        o_req.rd                 = rd;
        o_req.pc                 = i_pkt.pc;
        o_req.pc_next            = AW'(pc_ext + 32'd4);
        o_req.pc_target          = AW'(pc_ext + imm_b);
        o_req.branch_pred.taken  = i_pkt.pred_taken;
        o_req.branch_pred.target = i_pkt.pred_target;
        o_req.funct3             = funct3;
        o_req.reg_data2          = i_pkt.rs2_data;
        o_req.csr_data           = i_pkt.csr_data;
        case (opcode)
            OPC_OP:
            begin
                o_req.ctrl      = op_ctrl;
                o_req.res       = op_res;
                o_req.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                o_req.ctrl      = op_ctrl;
                o_req.res       = op_res;
                o_req.op2       = imm_i;
                o_req.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                o_req.op1       = '0;
                o_req.op2       = imm_u;
                o_req.reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                o_req.op1       = pc_ext;
                o_req.op2       = imm_u;
                o_req.reg_write = 1'b1;
            end
            OPC_JAL:
            begin
                o_req.res_src.pc_next = 1'b1;
                o_req.inst_jal_jalr   = 1'b1;
                o_req.reg_write       = 1'b1;
                o_req.pc_target       = AW'(pc_ext + imm_j);
            end
            OPC_JALR:
            begin
                o_req.op2             = imm_i;
                o_req.res_src.pc_next = 1'b1;
                o_req.inst_jal_jalr   = 1'b1;
                o_req.reg_write       = 1'b1;
                o_req.pc_target       = AW'({jalr_sum[31:1], 1'b0});
            end
            OPC_BRANCH:
            begin
                o_req.res              = '0;
                o_req.res.cmp          = 1'b1;
                o_req.inst_branch      = 1'b1;
                o_req.ctrl.cmp_lts     = (funct3[2:1] == 2'b10);
                o_req.ctrl.cmp_ltu     = (funct3[2:1] == 2'b11);
                o_req.ctrl.cmp_inversed = funct3[0];  // bne, bge and bgeu.
                o_req.to_trap          = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD:
            begin
                o_req.op2          = imm_i;
                o_req.res_src.load = 1'b1;
                o_req.reg_write    = 1'b1;
            end
            OPC_STORE:
            begin
                o_req.op2   = imm_s;
                o_req.store = 1'b1;
            end
            OPC_SYSTEM:
            begin
                o_req.csr_read  = (funct3[1:0] != 2'b00);  // ecall, ebreak and 100 trap.
                o_req.reg_write = o_req.csr_read;
                o_req.to_trap   = !o_req.csr_read;
            end
            default: o_req.to_trap = 1'b1;
        endcase
        if (o_req.to_trap)
        begin
            o_req.reg_write   = 1'b0;
            o_req.store       = 1'b0;
            o_req.inst_branch = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exec_unit
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_flush,
    input  wire                     i_pkt_valid,
    output logic                    o_pkt_ready,
    input  wire rv_pkg::fetch_pkt_t i_pkt,
    output logic                    o_rsp_valid,
    input  wire                     i_rsp_ready,
    output rv_pkg::exec_rsp_t       o_rsp
);

    rv_pkg::fetch_pkt_t buf_pkt;
    logic               buf_valid;
    rv_pkg::exec_req_t  dec_req;
    logic               alu_ready;
    rv_pkg::exec_rsp_t  alu_rsp;
    logic               alu_valid;
    logic               out_ready;

    rv_stage_buf #(
        .T          (rv_pkg::fetch_pkt_t)
    ) in_buf_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_valid    (i_pkt_valid),
        .o_ready    (o_pkt_ready),
        .i_data     (i_pkt),
        .o_valid    (buf_valid),
        .i_ready    (alu_ready),
        .o_data     (buf_pkt)
    );

    rv_decode decode_i (
        .i_pkt      (buf_pkt),
        .o_req      (dec_req)
    );

    rv_alu2 alu_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_valid    (buf_valid),
        .o_ready    (alu_ready),
        .i_req      (dec_req),
        .o_valid    (alu_valid),
        .i_ready    (out_ready),
        .o_rsp      (alu_rsp)
    );

    rv_stage_buf #(
        .T          (rv_pkg::exec_rsp_t)
    ) out_buf_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_valid    (alu_valid),
        .o_ready    (out_ready),
        .i_data     (alu_rsp),
        .o_valid    (o_rsp_valid),
        .i_ready    (i_rsp_ready),
        .o_data     (o_rsp)
    );

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef struct packed {
        logic arith_sub;
        logic arith_shr;          // selects the right shifter over the left one.
        logic shift_arithmetical;
        logic bits_xor;
        logic bits_or;            // neither xor nor or means and.
        logic cmp_lts;
        logic cmp_ltu;            // neither lts nor ltu means equality.
        logic cmp_inversed;
    } alu_ctrl_t;

    // one-hot result group.
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed {
        logic pc_next;
        logic load;
    } res_src_t;

    typedef struct packed {
        logic                      taken;
        logic [`RV_IADDR_BITS-1:0] target;
    } branch_pred_t;

    typedef struct packed {
        logic [31:0]               instr;
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [31:0]               rs1_data;
        logic [31:0]               rs2_data;
        logic [31:0]               csr_data;
        logic                      pred_taken;
        logic [`RV_IADDR_BITS-1:0] pred_target;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0]               op1;
        logic [31:0]               op2;
        alu_ctrl_t                 ctrl;
        alu_res_t                  res;
        res_src_t                  res_src;
        logic                      store;
        logic                      reg_write;
        logic [4:0]                rd;
        logic                      inst_jal_jalr;
        logic                      inst_branch;
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [`RV_IADDR_BITS-1:0] pc_next;
        logic [`RV_IADDR_BITS-1:0] pc_target;
        branch_pred_t              branch_pred;
        logic [2:0]                funct3;
        logic [31:0]               reg_data2;
        logic                      csr_read;
        logic [31:0]               csr_data;
        logic                      to_trap;
    } exec_req_t;

    typedef struct packed {
        logic [31:0]               result;
        logic [31:0]               addr;
        logic                      store;
        logic                      reg_write;
        logic [4:0]                rd;
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [`RV_IADDR_BITS-1:0] next_pc;
        logic                      redirect;
        res_src_t                  res_src;
        logic [31:0]               wdata;
        logic [3:0]                wsel;
        logic [2:0]                funct3;
        logic                      to_trap;
    } exec_rsp_t;

endpackage

`default_nettype wire

// ==== src/rv_stage_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_stage_buf
#(
    parameter type T = logic [31:0]
)
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   i_flush,
    input  wire   i_valid,
    output logic  o_ready,
    input  wire T i_data,
    output logic  o_valid,
    input  wire   i_ready,
    output T      o_data
);

    logic out_valid;
    logic skid_valid;
    T     out_data;
    T     skid_data;
    logic in_fire;
    logic load_out;

    assign in_fire  = i_valid && !skid_valid;     // ready is simply an empty skid slot.
    assign load_out = !out_valid || i_ready;      // the output register may take a new item.

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (load_out)
        begin
            out_valid  <= skid_valid || in_fire;  // the skid item goes first to keep order.
            skid_valid <= 1'b0;
        end
        else if (in_fire)
        begin
            skid_valid <= 1'b1;                   // downstream stalled, park the item.
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load_out)
            out_data <= skid_valid ? skid_data : i_data;
        if (!load_out && in_fire)
            skid_data <= i_data;
    end

    assign o_ready = !skid_valid;
    assign o_valid = out_valid;
    assign o_data  = out_data;

endmodule

`default_nettype wire

// ==== verification/rv_exec_vectors.txt ====
# instr pc rs1 rs2 csr pred_taken pred_target | mask(1 result,2 addr,4 wdata/wsel) result addr
# store reg_write rd next_pc redirect res_src wdata wsel to_trap
002081B3 100 7fffffff 1 0 0 0 3 80000000 80000000 0 1 3 104 0 0 0 0 0
402081B3 100 5 7 0 0 0 3 fffffffe fffffffe 0 1 3 104 0 0 0 0 0
0020C1B3 100 f0f0f0f0 ff00ff00 0 0 0 1 0ff00ff0 0 0 1 3 104 0 0 0 0 0
0020E1B3 100 f0f0f0f0 ff00ff00 0 0 0 1 fff0fff0 0 0 1 3 104 0 0 0 0 0
0020F1B3 100 f0f0f0f0 ff00ff00 0 0 0 1 f000f000 0 0 1 3 104 0 0 0 0 0
002091B3 100 1 1f 0 0 0 1 80000000 0 0 1 3 104 0 0 0 0 0
0020D1B3 100 80000000 1f 0 0 0 1 1 0 0 1 3 104 0 0 0 0 0
4020D1B3 100 80000000 1f 0 0 0 1 ffffffff 0 0 1 3 104 0 0 0 0 0
0020A1B3 100 80000000 1 0 0 0 1 1 0 0 1 3 104 0 0 0 0 0
0020B1B3 100 ffffffff 1 0 0 0 1 0 0 0 1 3 104 0 0 0 0 0
FFF08193 100 5 0 0 0 0 3 4 4 0 1 3 104 0 0 0 0 0
41F0D193 100 80000000 0 0 0 0 1 ffffffff 0 0 1 3 104 0 0 0 0 0
8000E193 100 12 0 0 0 0 1 fffff812 0 0 1 3 104 0 0 0 0 0
123451B7 100 0 0 0 0 0 1 12345000 0 0 1 3 104 0 0 0 0 0
00001197 100 0 0 0 0 0 1 1100 0 0 1 3 104 0 0 0 0 0
00208863 100 5 5 0 1 110 0 0 0 0 0 10 110 0 0 0 0 0
00209863 100 5 5 0 1 110 0 0 0 0 0 10 104 1 0 0 0 0
0020C863 100 ffffffff 1 0 0 0 0 0 0 0 0 10 110 1 0 0 0 0
0020D863 100 ffffffff 1 0 0 0 0 0 0 0 0 10 104 0 0 0 0 0
0020E863 100 1 ffffffff 0 1 110 0 0 0 0 0 10 110 0 0 0 0 0
0020F863 100 1 ffffffff 0 1 110 0 0 0 0 0 10 104 1 0 0 0 0
020001EF 100 0 0 0 0 0 1 104 0 0 1 3 120 1 2 0 0 0
005081E7 100 200 0 0 1 204 1 104 0 0 1 3 204 0 2 0 0 0
00208023 100 1000 a1b2c3d4 0 0 0 6 0 1000 1 0 0 104 0 0 d4d4d4d4 1 0
002080A3 100 1000 a1b2c3d4 0 0 0 6 0 1001 1 0 1 104 0 0 d4d4d4d4 2 0
002081A3 100 1000 a1b2c3d4 0 0 0 6 0 1003 1 0 3 104 0 0 d4d4d4d4 8 0
00209123 100 1000 a1b2c3d4 0 0 0 6 0 1002 1 0 2 104 0 0 c3d4c3d4 c 0
0020A023 100 1000 a1b2c3d4 0 0 0 6 0 1000 1 0 0 104 0 0 a1b2c3d4 f 0
0080A183 100 1000 0 0 0 0 2 0 1008 0 1 3 104 0 1 0 0 0
C00021F3 100 0 0 deadbeef 0 0 1 deadbeef 0 0 1 3 104 0 0 0 0 0
0000000B 100 0 0 0 0 0 0 0 0 0 0 0 104 0 0 0 0 1

// ==== verification/tb_rv_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_exec_unit;

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 200;
    localparam int AW      = `RV_IADDR_BITS;

    logic               i_clk;
    logic               i_reset;
    logic               i_flush;
    logic               i_pkt_valid;
    logic               o_pkt_ready;
    rv_pkg::fetch_pkt_t i_pkt;
    logic               o_rsp_valid;
    logic               i_rsp_ready;
    rv_pkg::exec_rsp_t  o_rsp;

    rv_pkg::fetch_pkt_t pkt_mem [MAX_VEC];
    rv_pkg::exec_rsp_t  exp_mem [MAX_VEC];
    logic [2:0]         mask_mem [MAX_VEC];
    int                 num_vec;
    int                 errors;
    int                 timeouts;
    int                 seed;
    int                 cycle;
    int                 accept_cycle;
    int                 rsp_cycle;

    rv_exec_unit rv_exec_unit_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_flush     (i_flush),
        .i_pkt_valid (i_pkt_valid),
        .o_pkt_ready (o_pkt_ready),
        .i_pkt       (i_pkt),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk)
        cycle <= cycle + 1;                          // stable when sampled on the falling edge.

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        timeouts++;
    endtask

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v [19];
        fd      = $fopen("verification/rv_exec_vectors.txt", "r");
        num_vec = 0;
        if (fd == 0)
        begin
            $display("Could not open the vector file");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && num_vec < MAX_VEC)
            begin
                line = "";
                cnt  = $fgets(line, fd);
                if (line.len() < 8 || line.getc(0) == "#")
                    continue;                        // comment or blank line.
                cnt = $sscanf(line,
                              "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                              v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
                if (cnt != 19)
                    continue;
                pkt_mem[num_vec]             = '0;
                pkt_mem[num_vec].instr       = v[0];
                pkt_mem[num_vec].pc          = v[1][AW-1:0];
                pkt_mem[num_vec].rs1_data    = v[2];
                pkt_mem[num_vec].rs2_data    = v[3];
                pkt_mem[num_vec].csr_data    = v[4];
                pkt_mem[num_vec].pred_taken  = v[5][0];
                pkt_mem[num_vec].pred_target = v[6][AW-1:0];
                mask_mem[num_vec]            = v[7][2:0];
                exp_mem[num_vec]             = '0;
                exp_mem[num_vec].result      = v[8];
                exp_mem[num_vec].addr        = v[9];
                exp_mem[num_vec].store       = v[10][0];
                exp_mem[num_vec].reg_write   = v[11][0];
                exp_mem[num_vec].rd          = v[12][4:0];
                exp_mem[num_vec].next_pc     = v[13][AW-1:0];
                exp_mem[num_vec].redirect    = v[14][0];
                exp_mem[num_vec].res_src     = v[15][1:0];
                exp_mem[num_vec].wdata       = v[16];
                exp_mem[num_vec].wsel        = v[17][3:0];
                exp_mem[num_vec].to_trap     = v[18][0];
                num_vec++;
            end
            $fclose(fd);
        end
    endtask

    task automatic check_field(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: vector %0d field %s is %h, expected %h",
                     $time, idx, name, got, exp);
        end
    endtask

    task automatic compare_rsp(input int idx);
        rv_pkg::exec_rsp_t exp;
        exp = exp_mem[idx];
        check_field(idx, "store", 32'(o_rsp.store), 32'(exp.store));
        check_field(idx, "reg_write", 32'(o_rsp.reg_write), 32'(exp.reg_write));
        check_field(idx, "rd", 32'(o_rsp.rd), 32'(exp.rd));
        check_field(idx, "pc", 32'(o_rsp.pc), 32'(pkt_mem[idx].pc));
        check_field(idx, "funct3", 32'(o_rsp.funct3), 32'(pkt_mem[idx].instr[14:12]));
        check_field(idx, "next_pc", 32'(o_rsp.next_pc), 32'(exp.next_pc));
        check_field(idx, "redirect", 32'(o_rsp.redirect), 32'(exp.redirect));
        check_field(idx, "res_src", 32'(o_rsp.res_src), 32'(exp.res_src));
        check_field(idx, "to_trap", 32'(o_rsp.to_trap), 32'(exp.to_trap));
        if (mask_mem[idx][0])
            check_field(idx, "result", o_rsp.result, exp.result);
        if (mask_mem[idx][1])
            check_field(idx, "addr", o_rsp.addr, exp.addr);
        if (mask_mem[idx][2])
        begin
            check_field(idx, "wdata", o_rsp.wdata, exp.wdata);
            check_field(idx, "wsel", 32'(o_rsp.wsel), 32'(exp.wsel));
        end
    endtask

    // called a little after a rising edge; returns at the same point of a later cycle.
    task automatic send_range(input int first, input int last);
        int wait_cycles;
        for (int i = first; i <= last && timeouts == 0; i++)
        begin
            i_pkt_valid = 1'b1;
            i_pkt       = pkt_mem[i];
            wait_cycles = 0;
            @(negedge i_clk);
            while (!o_pkt_ready && timeouts == 0)
            begin
                wait_cycles++;
                if (wait_cycles > TIMEOUT)
                    report_timeout("o_pkt_ready");
                else
                    @(negedge i_clk);
            end
            if (timeouts == 0)
            begin
                if (i == first)
                    accept_cycle = cycle;
                @(posedge i_clk);
                #1;
            end
        end
        i_pkt_valid = 1'b0;
    endtask

    task automatic update_ready(input bit random_ready);
        i_rsp_ready = random_ready ? 1'($random(seed)) : 1'b1;
    endtask

    task automatic collect_range(input int first, input int last, input bit random_ready);
        int wait_cycles;
        for (int i = first; i <= last && timeouts == 0; i++)
        begin
            wait_cycles = 0;
            @(negedge i_clk);
            while (!(o_rsp_valid && i_rsp_ready) && timeouts == 0)
            begin
                wait_cycles++;
                if (wait_cycles > TIMEOUT)
                    report_timeout("a response");
                else
                begin
                    @(posedge i_clk);
                    #1;
                    update_ready(random_ready);
                    @(negedge i_clk);
                end
            end
            if (timeouts == 0)
            begin
                compare_rsp(i);
                if (i == first)
                    rsp_cycle = cycle;
                @(posedge i_clk);
                #1;
                update_ready(random_ready);
            end
        end
    endtask

    // with the output ready, nothing may come out once every vector is collected.
    task automatic check_drained();
        i_rsp_ready = 1'b1;
        repeat (5)
        begin
            @(negedge i_clk);
            assert (!o_rsp_valid)
            else
            begin
                errors++;
                $display("Mismatch at %0t: response beyond the last vector", $time);
            end
            @(posedge i_clk);
            #1;
        end
    endtask

    initial
    begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_flush     = 1'b0;
        i_pkt_valid = 1'b0;
        i_pkt       = '0;
        i_rsp_ready = 1'b0;
        errors      = 0;
        timeouts    = 0;
        seed        = 78652;
        cycle       = 0;
        load_vectors();
        repeat (5) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        if (num_vec < 4)
        begin
            $display("Only %0d vectors loaded, at least 4 are needed", num_vec);
            errors++;
        end
        else
        begin
            // latency with the output always ready.
            i_rsp_ready = 1'b1;
            fork
                send_range(0, 0);
                collect_range(0, 0, 1'b0);
            join
            if (timeouts == 0)
            begin
                assert (rsp_cycle - accept_cycle == 3)
                else
                begin
                    errors++;
                    $display("Mismatch at %0t: latency is %0d cycles, expected 3",
                             $time, rsp_cycle - accept_cycle);
                end
            end

            // every vector under random back-pressure.
            fork
                send_range(0, num_vec - 1);
                collect_range(0, num_vec - 1, 1'b1);
            join
            if (timeouts == 0)
                check_drained();

            // three items stall in the pipeline and are flushed.
            i_rsp_ready = 1'b0;
            send_range(0, 2);
            if (timeouts == 0)
            begin
                i_flush = 1'b1;
                @(posedge i_clk);
                #1;
                i_flush = 1'b0;
                @(negedge i_clk);
                assert (!o_rsp_valid && o_pkt_ready)
                else
                begin
                    errors++;
                    $display("Mismatch at %0t: pipeline not empty after flush", $time);
                end
                @(posedge i_clk);
                #1;
            end
            fork
                send_range(3, num_vec - 1);
                collect_range(3, num_vec - 1, 1'b1);
            join
            if (timeouts == 0)
                check_drained();
        end

        finish_run();
    end

endmodule

`default_nettype wire
